// File: logic/lenet_pkg.sv
package lenet_pkg;

    // ====================
    // geometry
    // ====================
    localparam int kernel_size = 5;
    localparam int load_count  = kernel_size * kernel_size + 1; // 25 weights, then the bias
    localparam int out_shift   = 8;

    // ====================
    // widths
    // ====================
    localparam int pixel_w        = 8;
    localparam int weight_w       = 8;
    localparam int product_w      = 16;
    localparam int row_sum_w      = 19;   // five products
    localparam int acc_w          = 21;   // 25 products plus bias
    localparam int bias_w         = 16;
    localparam int feature_w      = 8;
    localparam int feature_max    = 2 ** feature_w - 1;
    localparam int approx_term_w  = 13;   // reduced partial product vectors
    localparam int beat_w         = $clog2(load_count);
    localparam int row_idx_w      = $clog2(kernel_size);

    typedef logic [pixel_w-1:0]   pixel_t;
    typedef logic [weight_w-1:0]  weight_t;
    typedef logic [product_w-1:0] product_t;
    typedef logic [row_sum_w-1:0] row_sum_t;
    typedef logic [acc_w-1:0]     acc_t;
    typedef logic [bias_w-1:0]    bias_t;
    typedef logic [feature_w-1:0] feature_t;

    // one window row, element 0 in the low byte
    typedef struct packed {
        pixel_t [kernel_size-1:0] px;
    } pixel_row_t;

    typedef struct packed {
        weight_t [kernel_size-1:0] w;
    } weight_row_t;

    // row sum on its way to the accumulator
    typedef struct packed {
        row_sum_t sum;
        logic     last;   // fifth row of a window
    } row_beat_t;

    typedef enum logic {
        loading,
        armed
    } store_state_t;

endpackage

// File: logic/approx_mult_8x8.sv
`timescale 1ns/10ps

module approx_mult_8x8 (
    input  lenet_pkg::weight_t  x,
    input  lenet_pkg::pixel_t   y,
    output lenet_pkg::product_t z
);

    lenet_pkg::pixel_t pp [8];                           // partial product rows
    logic [lenet_pkg::approx_term_w-1:0] term [7];       // reduced rows 0 to 5

    // ====================
    // partial products
    // ====================
    always_comb begin
        for (int k = 0; k < 8; k++) begin
            pp[k] = y & {8{x[k]}};
        end
    end

    // ====================
    // reduction table
    // ====================
    // rows 0..5 squeezed pairwise into seven sparse vectors,
    // nothing survives below weight 16
    always_comb begin
        for (int v = 0; v < 7; v++) begin
            term[v] = '0;
        end

        term[0][4]  = pp[0][4] | pp[1][3];
        term[0][5]  = pp[0][5] | pp[1][4];
        term[0][6]  = pp[4][1] ^ pp[5][0];
        term[0][7]  = pp[4][3] & pp[5][2];
        term[0][8]  = pp[0][7] ^ pp[1][6];
        term[0][9]  = pp[2][7] | pp[3][6];
        term[0][10] = pp[3][7];
        term[0][11] = pp[4][7] ^ pp[5][6];                  // sum bit of the top pair
        term[0][12] = pp[4][7] & pp[5][6];                  // and its carry

        term[1][4]  = pp[0][4] ^ pp[1][3];
        term[1][8]  = pp[2][5] & pp[3][4];
        term[1][9]  = pp[4][5] ^ pp[5][4];
        term[1][10] = pp[4][5] & pp[5][4];
        term[1][12] = pp[5][7];

        term[2][8]  = pp[2][5] | pp[3][4];
        term[2][10] = pp[4][6] & pp[5][5];

        term[3][8]  = pp[2][6] | pp[3][5];
        term[3][10] = pp[4][6] | pp[5][5];

        // low half of rows 4/5 all lands on weight 256
        term[4][8]  = pp[4][3] | pp[5][2];
        term[5][8]  = pp[4][4] & pp[5][3];
        term[6][8]  = pp[4][4] | pp[5][3];
    end

    // ====================
    // final sum
    // ====================
    // rows 6 and 7 go in exact
    assign z = lenet_pkg::product_t'({pp[6], 6'b0})
             + lenet_pkg::product_t'({pp[7], 7'b0})
             + lenet_pkg::product_t'(term[0])
             + lenet_pkg::product_t'(term[1])
             + lenet_pkg::product_t'(term[2])
             + lenet_pkg::product_t'(term[3])
             + lenet_pkg::product_t'(term[4])
             + lenet_pkg::product_t'(term[5])
             + lenet_pkg::product_t'(term[6]);

endmodule

// File: logic/kernel_weight_store.sv
`timescale 1ns/10ps

module kernel_weight_store (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         load_valid,
    input  logic [lenet_pkg::bias_w-1:0] load_data,
    input  logic                         row_accept,
    output lenet_pkg::weight_row_t       weight_row,
    output logic                         row_last,
    output lenet_pkg::bias_t             bias,
    output logic                         armed
);

    lenet_pkg::store_state_t               state;
    logic [lenet_pkg::beat_w-1:0]          beat_cnt;
    logic [lenet_pkg::beat_w-1:0]          wr_beat;
    logic [lenet_pkg::row_idx_w-1:0]       row_cnt;
    lenet_pkg::weight_row_t                rows [lenet_pkg::kernel_size];

    // a beat arriving while armed starts a fresh kernel at beat 0
    assign wr_beat = (state == lenet_pkg::armed) ? '0 : beat_cnt;

    always_ff @(posedge clk) begin
        if (reset) begin
            state    <= lenet_pkg::loading;
            beat_cnt <= '0;
        end else if (load_valid) begin
            if (wr_beat == lenet_pkg::load_count - 1) begin
                state    <= lenet_pkg::armed;       // bias beat closes the load
                beat_cnt <= '0;
            end else begin
                state    <= lenet_pkg::loading;
                beat_cnt <= wr_beat + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_valid) begin
            if (wr_beat == lenet_pkg::load_count - 1) begin
                bias <= load_data;
            end else begin
                rows[wr_beat / lenet_pkg::kernel_size].w[wr_beat % lenet_pkg::kernel_size]
                    <= load_data[lenet_pkg::weight_w-1:0];
            end
        end
    end

    // row position inside the current window
    always_ff @(posedge clk) begin
        if (reset) begin
            row_cnt <= '0;
        end else if (load_valid) begin
            row_cnt <= '0;                          // partial window is abandoned
        end else if (row_accept) begin
            row_cnt <= (row_cnt == lenet_pkg::kernel_size - 1) ? '0 : row_cnt + 1'b1;
        end
    end

    assign weight_row = rows[row_cnt];
    assign armed      = (state == lenet_pkg::armed);
    // held high while loading so idle slots in the pipe flush any partial sum
    assign row_last   = (row_accept && row_cnt == lenet_pkg::kernel_size - 1) || !armed;

    // the top must keep row_ready low until the kernel is complete
    accept_only_armed: assert property (@(posedge clk) disable iff (reset)
        row_accept |-> state == lenet_pkg::armed);

endmodule

// File: logic/row_dot_pipe.sv
`timescale 1ns/10ps

module row_dot_pipe (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    advance,
    input  logic                    in_valid,
    input  lenet_pkg::pixel_row_t   pixels,
    input  lenet_pkg::weight_row_t  weights,
    input  logic                    in_last,
    output logic                    beat_valid,
    output lenet_pkg::row_beat_t    beat
);

    lenet_pkg::product_t prod    [lenet_pkg::kernel_size];
    lenet_pkg::product_t s1_prod [lenet_pkg::kernel_size];
    logic                s1_valid;
    logic                s1_last;
    lenet_pkg::row_sum_t s1_sum;
    lenet_pkg::row_sum_t s2_sum;
    logic                s2_last;

    // ====================
    // multipliers
    // ====================
    for (genvar i = 0; i < lenet_pkg::kernel_size; i++) begin : g_mult
        approx_mult_8x8 u_mult (
            .x (weights.w[i]),
            .y (pixels.px[i]),
            .z (prod[i])
        );
    end

    // ====================
    // stage 1: products
    // ====================
    always_ff @(posedge clk) begin
        if (advance) begin
            s1_prod <= prod;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            s1_valid <= 1'b0;
            s1_last  <= 1'b0;
        end else if (advance) begin
            s1_valid <= in_valid;
            s1_last  <= in_last;                    // kept on empty slots too
        end
    end

    always_comb begin
        s1_sum = '0;
        for (int i = 0; i < lenet_pkg::kernel_size; i++) begin
            s1_sum = s1_sum + lenet_pkg::row_sum_t'(s1_prod[i]);
        end
    end

    // ====================
    // stage 2: row sum
    // ====================
    always_ff @(posedge clk) begin
        if (advance) begin
            s2_sum <= s1_sum;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            beat_valid <= 1'b0;
            s2_last    <= 1'b0;
        end else if (advance) begin
            beat_valid <= s1_valid;
            s2_last    <= s1_last;
        end
    end

    assign beat.sum  = s2_sum;
    assign beat.last = s2_last;

endmodule

// File: logic/window_accumulator.sv
`timescale 1ns/10ps

module window_accumulator (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 beat_valid,
    input  lenet_pkg::row_beat_t beat,
    input  lenet_pkg::bias_t     bias,
    output logic                 feature_valid,
    input  logic                 feature_ready,
    output lenet_pkg::feature_t  feature,
    output logic                 advance
);

    lenet_pkg::acc_t     run_sum;    // rows seen so far in this window
    lenet_pkg::acc_t     total;
    lenet_pkg::acc_t     scaled;
    lenet_pkg::feature_t clamped;
    logic                take;
    logic                finish;

    // the whole engine moves only when the output slot is free or draining
    assign advance = !feature_valid || feature_ready;

    assign take   = advance && beat_valid;
    assign finish = take && beat.last;

    // ====================
    // scale and clamp
    // ====================
    always_comb begin
        total  = run_sum + lenet_pkg::acc_t'(beat.sum) + lenet_pkg::acc_t'(bias);
        scaled = total >> lenet_pkg::out_shift;
        if (scaled > lenet_pkg::acc_t'(lenet_pkg::feature_max)) begin
            clamped = lenet_pkg::feature_t'(lenet_pkg::feature_max);
        end else begin
            clamped = lenet_pkg::feature_t'(scaled);
        end
    end

    // ====================
    // running sum
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            run_sum <= '0;
        end else if (advance) begin
            if (beat_valid && !beat.last) begin
                run_sum <= run_sum + lenet_pkg::acc_t'(beat.sum);
            end else if (beat.last) begin
                run_sum <= '0;                      // end of window, or a flush slot
            end
        end
    end

    // ====================
    // output register
    // ====================
    always_ff @(posedge clk) begin
        if (reset) begin
            feature_valid <= 1'b0;
        end else if (advance) begin
            feature_valid <= finish;
        end
    end

    always_ff @(posedge clk) begin
        if (finish) begin
            feature <= clamped;
        end
    end

    // a stalled feature must not change under the consumer
    feature_hold: assert property (@(posedge clk) disable iff (reset)
        feature_valid && !feature_ready |=> feature_valid && $stable(feature));

endmodule

// File: logic/conv_engine_top.sv
`timescale 1ns/10ps

module conv_engine_top (
    input  logic                         clk,
    input  logic                         reset,
    input  logic                         load_valid,
    input  logic [lenet_pkg::bias_w-1:0] load_data,
    input  logic                         row_valid,
    output logic                         row_ready,
    input  lenet_pkg::pixel_row_t        row_data,
    output logic                         feature_valid,
    input  logic                         feature_ready,
    output lenet_pkg::feature_t          feature
);

    lenet_pkg::weight_row_t weight_row;
    lenet_pkg::bias_t       bias;
    lenet_pkg::row_beat_t   beat;
    logic                   row_last;
    logic                   armed;
    logic                   advance;
    logic                   row_accept;
    logic                   beat_valid;

    assign row_ready  = armed & advance;
    assign row_accept = row_valid & row_ready;

    kernel_weight_store u_store (
        .clk        (clk),
        .reset      (reset),
        .load_valid (load_valid),
        .load_data  (load_data),
        .row_accept (row_accept),
        .weight_row (weight_row),
        .row_last   (row_last),
        .bias       (bias),
        .armed      (armed)
    );

    row_dot_pipe u_pipe (
        .clk        (clk),
        .reset      (reset),
        .advance    (advance),
        .in_valid   (row_accept),
        .pixels     (row_data),
        .weights    (weight_row),
        .in_last    (row_last),
        .beat_valid (beat_valid),
        .beat       (beat)
    );

    window_accumulator u_acc (
        .clk           (clk),
        .reset         (reset),
        .beat_valid    (beat_valid),
        .beat          (beat),
        .bias          (bias),
        .feature_valid (feature_valid),
        .feature_ready (feature_ready),
        .feature       (feature),
        .advance       (advance)
    );

endmodule

// File: include/approx_model.svh
`ifndef APPROX_MODEL_SVH
`define APPROX_MODEL_SVH

// bit-level twin of approx_mult_8x8, same terms at the same weights
function automatic lenet_pkg::product_t approx_mult_model(
    input lenet_pkg::weight_t x,
    input lenet_pkg::pixel_t  y
);
    lenet_pkg::pixel_t   pp [8];
    lenet_pkg::product_t z;
    for (int k = 0; k < 8; k++) begin
        pp[k] = y & {8{x[k]}};
    end
    z = lenet_pkg::product_t'({pp[6], 6'b0}) + lenet_pkg::product_t'({pp[7], 7'b0});
    z += lenet_pkg::product_t'(pp[0][4] | pp[1][3]) << 4;
    z += lenet_pkg::product_t'(pp[0][5] | pp[1][4]) << 5;
    z += lenet_pkg::product_t'(pp[4][1] ^ pp[5][0]) << 6;
    z += lenet_pkg::product_t'(pp[4][3] & pp[5][2]) << 7;
    z += lenet_pkg::product_t'(pp[0][7] ^ pp[1][6]) << 8;
    z += lenet_pkg::product_t'(pp[2][7] | pp[3][6]) << 9;
    z += lenet_pkg::product_t'(pp[3][7]) << 10;
    z += lenet_pkg::product_t'(pp[4][7] ^ pp[5][6]) << 11;
    z += lenet_pkg::product_t'(pp[4][7] & pp[5][6]) << 12;
    z += lenet_pkg::product_t'(pp[0][4] ^ pp[1][3]) << 4;
    z += lenet_pkg::product_t'(pp[2][5] & pp[3][4]) << 8;
    z += lenet_pkg::product_t'(pp[4][5] ^ pp[5][4]) << 9;
    z += lenet_pkg::product_t'(pp[4][5] & pp[5][4]) << 10;
    z += lenet_pkg::product_t'(pp[5][7]) << 12;
    z += lenet_pkg::product_t'(pp[2][5] | pp[3][4]) << 8;
    z += lenet_pkg::product_t'(pp[4][6] & pp[5][5]) << 10;
    z += lenet_pkg::product_t'(pp[2][6] | pp[3][5]) << 8;
    z += lenet_pkg::product_t'(pp[4][6] | pp[5][5]) << 10;
    z += lenet_pkg::product_t'(pp[4][3] | pp[5][2]) << 8;
    z += lenet_pkg::product_t'(pp[4][4] & pp[5][3]) << 8;
    z += lenet_pkg::product_t'(pp[4][4] | pp[5][3]) << 8;
    return z;
endfunction

// one full window through the engine arithmetic
function automatic lenet_pkg::feature_t window_model(
    input lenet_pkg::weight_row_t w [lenet_pkg::kernel_size],
    input lenet_pkg::pixel_row_t  p [lenet_pkg::kernel_size],
    input lenet_pkg::bias_t       b
);
    lenet_pkg::acc_t total;
    total = lenet_pkg::acc_t'(b);
    for (int r = 0; r < lenet_pkg::kernel_size; r++) begin
        for (int c = 0; c < lenet_pkg::kernel_size; c++) begin
            total += lenet_pkg::acc_t'(approx_mult_model(w[r].w[c], p[r].px[c]));
        end
    end
    total = total >> lenet_pkg::out_shift;
    if (total > lenet_pkg::acc_t'(lenet_pkg::feature_max)) begin
        return lenet_pkg::feature_t'(lenet_pkg::feature_max);
    end
    return lenet_pkg::feature_t'(total);
endfunction

`endif

// File: tests/conv_engine_tb.sv
`timescale 1ns/10ps

module conv_engine_tb;

    `include "approx_model.svh"

    localparam int reset_cycles  = 8;
    localparam int rows_per_test = 8 * lenet_pkg::kernel_size;   // eight windows
    localparam int drain_cycles  = 30;
    localparam int test_cycles   = 2 * lenet_pkg::load_count + 3 * rows_per_test + drain_cycles;
    localparam int cycle_limit   = reset_cycles + 6 * (test_cycles + 4) + 100;

    logic                         clk;
    logic                         reset;
    logic                         load_valid;
    logic [lenet_pkg::bias_w-1:0] load_data;
    logic                         row_valid;
    logic                         row_ready;
    lenet_pkg::pixel_row_t        row_data;
    logic                         feature_valid;
    logic                         feature_ready;
    lenet_pkg::feature_t          feature;

    logic [15:0] stim_lfsr  = 16'd16421;
    logic [15:0] ready_lfsr = 16'd16421;
    logic        random_ready;
    logic        exact_mode;
    int          cycle_cnt    = 0;
    int          errors       = 0;
    int          errors_seen  = 0;
    int          test_count   = 0;
    int          failed_tests = 0;

    // reference state kept from what crosses the ports
    lenet_pkg::weight_row_t kern [lenet_pkg::kernel_size];
    lenet_pkg::bias_t       kern_bias;
    lenet_pkg::pixel_row_t  win [lenet_pkg::kernel_size];
    int                     win_row;
    int                     load_idx;
    int                     beat_idx;
    logic                   armed_m;
    lenet_pkg::feature_t    exp_q [$];
    lenet_pkg::feature_t    exp_head;
    int                     exp_count;
    logic                   model_armed;

    conv_engine_top uut (
        .clk           (clk),
        .reset         (reset),
        .load_valid    (load_valid),
        .load_data     (load_data),
        .row_valid     (row_valid),
        .row_ready     (row_ready),
        .row_data      (row_data),
        .feature_valid (feature_valid),
        .feature_ready (feature_ready),
        .feature       (feature)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};   // taps 16 14 13 11
    endfunction

    function automatic logic [15:0] rand_bits(input int n);
        logic [15:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            stim_lfsr = lfsr_step(stim_lfsr);
            v = {v[14:0], stim_lfsr[0]};
        end
        return v;
    endfunction

    // plain arithmetic of the feature rule, no approximation
    function automatic lenet_pkg::feature_t exact_feature(
        input lenet_pkg::weight_row_t w [lenet_pkg::kernel_size],
        input lenet_pkg::pixel_row_t  p [lenet_pkg::kernel_size],
        input lenet_pkg::bias_t       b
    );
        int unsigned total;
        total = b;
        for (int r = 0; r < lenet_pkg::kernel_size; r++) begin
            for (int c = 0; c < lenet_pkg::kernel_size; c++) begin
                total += int'(w[r].w[c]) * int'(p[r].px[c]);
            end
        end
        total = total >> lenet_pkg::out_shift;
        return (total > 255) ? 8'd255 : lenet_pkg::feature_t'(total);
    endfunction

    // ====================
    // scoreboard
    // ====================
    always @(posedge clk) begin
        if (reset) begin
            exp_q.delete();
            win_row  = 0;
            load_idx = 0;
            armed_m  = 1'b0;
        end else begin
            if (feature_valid && feature_ready && exp_q.size() != 0) begin
                void'(exp_q.pop_front());
            end
            if (row_valid && row_ready) begin
                win[win_row] = row_data;
                if (win_row == lenet_pkg::kernel_size - 1) begin
                    exp_q.push_back(exact_mode ? exact_feature(kern, win, kern_bias)
                                               : window_model(kern, win, kern_bias));
                    win_row = 0;
                end else begin
                    win_row++;
                end
            end
            if (load_valid) begin
                beat_idx = armed_m ? 0 : load_idx;   // reload starts over
                win_row  = 0;
                if (beat_idx == lenet_pkg::load_count - 1) begin
                    kern_bias = load_data;
                    armed_m   = 1'b1;
                    load_idx  = 0;
                end else begin
                    kern[beat_idx / 5].w[beat_idx % 5] = load_data[7:0];
                    armed_m  = 1'b0;
                    load_idx = beat_idx + 1;
                end
            end
        end
        model_armed <= armed_m;
        exp_count   <= exp_q.size();
        exp_head    <= (exp_q.size() != 0) ? exp_q[0] : '0;
    end

    feature_match: assert property (@(posedge clk) disable iff (reset)
        feature_valid && feature_ready && exp_count != 0 |-> feature == exp_head)
        else begin
            $display("Mismatch feature: got %h expected %h", $sampled(feature), $sampled(exp_head));
            errors++;
        end

    no_extra_feature: assert property (@(posedge clk) disable iff (reset)
        feature_valid |-> exp_count != 0)
        else begin
            $display("feature presented with no window outstanding");
            errors++;
        end

    feature_stable: assert property (@(posedge clk) disable iff (reset)
        feature_valid && !feature_ready |=> feature_valid && $stable(feature))
        else begin
            $display("feature changed or vanished while the consumer stalled");
            errors++;
        end

    ready_only_armed: assert property (@(posedge clk) disable iff (reset)
        !model_armed |-> !row_ready)
        else begin
            $display("row_ready high before the kernel was complete");
            errors++;
        end

    ready_when_free: assert property (@(posedge clk) disable iff (reset)
        model_armed && (!feature_valid || feature_ready) |-> row_ready)
        else begin
            $display("row_ready low with a loaded kernel and a free output");
            errors++;
        end

    // ====================
    // stimulus
    // ====================
    always @(posedge clk) begin
        if (random_ready) begin
            ready_lfsr = lfsr_step(ready_lfsr);
            feature_ready <= ready_lfsr[0];
        end else begin
            feature_ready <= 1'b1;
        end
    end

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == cycle_limit) begin
            $display("run stopped after %0d cycles without finishing", cycle_cnt);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic load_kernel(input lenet_pkg::weight_t wmask, input lenet_pkg::weight_t wforce,
                               input lenet_pkg::bias_t bmask);
        for (int i = 0; i < lenet_pkg::load_count; i++) begin
            load_valid <= 1'b1;
            if (i == lenet_pkg::load_count - 1) begin
                load_data <= rand_bits(16) & bmask;          // bias beat
            end else begin
                load_data <= {8'h00, (lenet_pkg::weight_t'(rand_bits(8)) & wmask) | wforce};
            end
            @(posedge clk);
        end
        load_valid <= 1'b0;
    endtask

    task automatic send_rows(input int n, input lenet_pkg::pixel_t pmask,
                             input lenet_pkg::pixel_t pforce, input logic gaps);
        lenet_pkg::pixel_row_t r;
        for (int i = 0; i < n; i++) begin
            if (gaps) begin
                if (rand_bits(1) != 0) begin
                    row_valid <= 1'b0;                   // source idles one cycle
                    @(posedge clk);
                end
            end
            for (int c = 0; c < lenet_pkg::kernel_size; c++) begin
                r.px[c] = (lenet_pkg::pixel_t'(rand_bits(8)) & pmask) | pforce;
            end
            row_data  <= r;
            row_valid <= 1'b1;
            @(posedge clk);
            while (!row_ready) begin
                @(posedge clk);
            end
        end
        row_valid <= 1'b0;
    endtask

    task automatic close_test(input string name);
        for (int i = 0; i < drain_cycles && exp_count != 0; i++) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
        drained: assert (exp_count == 0) else begin
            $display("%0d expected features never came out", exp_count);
            errors++;
        end
        test_count++;
        if (errors != errors_seen) begin
            failed_tests++;
        end
        $display("test %0d %s: %0d errors", test_count, name, errors - errors_seen);
        errors_seen = errors;
    endtask

    initial begin
        reset         = 1'b1;
        load_valid    = 1'b0;
        load_data     = '0;
        row_valid     = 1'b0;
        row_data      = '0;
        feature_ready = 1'b1;
        random_ready  = 1'b0;
        exact_mode    = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        reset <= 1'b0;

        repeat (20) @(posedge clk);   // idle with no kernel
        load_kernel(8'hff, 8'h00, 16'h0fff);
        repeat (4) @(posedge clk);
        close_test("reset and load");

        exact_mode <= 1'b1;
        load_kernel(8'hc0, 8'h00, 16'h0fff);
        send_rows(rows_per_test, 8'h0f, 8'h00, 1'b0);
        close_test("exact top weight bits");
        exact_mode <= 1'b0;

        load_kernel(8'hff, 8'h00, 16'h0fff);
        send_rows(rows_per_test, 8'h1f, 8'h00, 1'b0);
        close_test("random back to back");

        load_kernel(8'h00, 8'hff, 16'hffff);
        send_rows(rows_per_test, 8'h00, 8'hff, 1'b0);
        close_test("saturation");

        random_ready <= 1'b1;
        load_kernel(8'hff, 8'h00, 16'h0fff);
        send_rows(rows_per_test, 8'h1f, 8'h00, 1'b1);
        random_ready <= 1'b0;
        close_test("output stalls");

        load_kernel(8'hff, 8'h00, 16'h0fff);
        send_rows(2 * lenet_pkg::kernel_size + 3, 8'h1f, 8'h00, 1'b0);   // stops inside window 3
        load_kernel(8'hff, 8'h00, 16'h0fff);
        send_rows(rows_per_test, 8'h1f, 8'h00, 1'b0);
        close_test("reload mid window");

        $display("%0d tests, %0d failed, %0d errors", test_count, failed_tests, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// File: conv_engine_top.f
+incdir+include
logic/lenet_pkg.sv
logic/approx_mult_8x8.sv
logic/kernel_weight_store.sv
logic/row_dot_pipe.sv
logic/window_accumulator.sv
logic/conv_engine_top.sv
tests/conv_engine_tb.sv
